// File: hw/ddr_seq_pkg.sv
// ----------------------------------------------------------
// ddr3 command sequencer shared definitions
// widths, command word views, axi4-lite write bus and
// registered command line bundles
// ----------------------------------------------------------
package ddr_seq_pkg;

    localparam int CMD_PAUSE_BITS = 6;      // nop pause length field
    localparam int DDR_ADDR_BITS  = 15;     // row/column address
    localparam int DDR_BA_BITS    = 3;      // bank address
    localparam int CMD_BANK_AW    = 8;      // 256 words per bank
    localparam int CMD_MEM_AW     = 9;      // bank bit on top
    localparam int CMD_WORD_BITS  = 32;

    localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

    // active command view
    typedef struct packed {
        logic [8:0]               rsvd;     // 31..23
        logic                     odt;      // 22
        logic                     cke;      // 21
        logic                     ras_n;    // 20
        logic                     cas_n;    // 19
        logic                     we_n;     // 18
        logic [DDR_BA_BITS-1:0]   ba;       // 17..15
        logic [DDR_ADDR_BITS-1:0] addr;     // 14..0
    } cmd_active_t;

    // nop view, ras/cas/we at the same positions
    typedef struct packed {
        logic [10:0]               rsvd_hi; // 31..21
        logic                      ras_n;
        logic                      cas_n;
        logic                      we_n;
        logic [10:0]               rsvd_lo; // 17..7
        logic                      done;    // end of sequence after pause
        logic [CMD_PAUSE_BITS-1:0] pause;   // stall cycles
    } cmd_nop_t;

    typedef union packed {
        cmd_active_t active;
        cmd_nop_t    nop;
    } cmd_word_u;

    // registered ddr3 command lines
    typedef struct packed {
        logic                     ras_n;
        logic                     cas_n;
        logic                     we_n;
        logic [DDR_BA_BITS-1:0]   ba;
        logic [DDR_ADDR_BITS-1:0] addr;
        logic                     cke;
        logic                     odt;
    } ddr_cmd_t;

    typedef struct packed {
        logic [11:0]                awaddr;
        logic                       awvalid;
        logic [CMD_WORD_BITS-1:0]   wdata;
        logic [CMD_WORD_BITS/8-1:0] wstrb;
        logic                       wvalid;
        logic                       bready;
    } axil_wreq_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
    } axil_wrsp_t;

    // command memory write port
    typedef struct packed {
        logic                       en;
        logic [CMD_MEM_AW-1:0]      addr;
        logic [CMD_WORD_BITS-1:0]   data;
        logic [CMD_WORD_BITS/8-1:0] strb;
    } mem_wr_t;

endpackage

// File: hw/cmd_axil_wr.sv
// ----------------------------------------------------------
// axi4-lite write slave for the command memory
// accepts address and data together with one write in flight
// and turns each accepted beat into a byte-enabled memory write
// ----------------------------------------------------------
module cmd_axil_wr (
    input  logic                    mclk,
    input  logic                    rst,
    input  ddr_seq_pkg::axil_wreq_t wreq,
    output ddr_seq_pkg::axil_wrsp_t wrsp,
    output ddr_seq_pkg::mem_wr_t    mem_wr
);
    import ddr_seq_pkg::*;

    logic accept;   // aw and w handshake this cycle
    logic bvalid;   // response pending

    // both channels valid and no response waiting
    assign accept = wreq.awvalid && wreq.wvalid && !bvalid;

    assign wrsp.awready = accept;
    assign wrsp.wready  = accept;
    assign wrsp.bvalid  = bvalid;
    assign wrsp.bresp   = AXIL_RESP_OKAY;   // every write succeeds

    // word address from byte address bits 10..2 with bit 10 as bank
    assign mem_wr.en   = accept;
    assign mem_wr.addr = wreq.awaddr[CMD_MEM_AW+1:2];
    assign mem_wr.data = wreq.wdata;
    assign mem_wr.strb = wreq.wstrb;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (accept) begin
            bvalid <= 1'b1;                 // answer next cycle
        end else if (wreq.bready) begin
            bvalid <= 1'b0;                 // master took it
        end
    end

    // a pending response waits for bready
    property p_bvalid_held;
        @(posedge mclk) disable iff (rst)
        (bvalid && !wreq.bready) |=> bvalid;
    endproperty

    a_bvalid_held : assert property (p_bvalid_held)
        else $error("write response dropped before bready");

endmodule

// File: hw/cmd_mem.sv
// ----------------------------------------------------------
// two-bank command memory
// bank 0 in the low 256 words, bank 1 in the high 256,
// byte-enabled writes and a registered read port
// ----------------------------------------------------------
module cmd_mem (
    input  logic                                mclk,
    input  ddr_seq_pkg::mem_wr_t                wr,
    input  logic                                rd_en,
    input  logic [ddr_seq_pkg::CMD_MEM_AW-1:0]  rd_addr,
    output ddr_seq_pkg::cmd_word_u              rd_word
);
    import ddr_seq_pkg::*;

    logic [CMD_WORD_BITS-1:0] mem [2**CMD_MEM_AW];  // both banks

    // one byte lane per strobe bit
    always_ff @(posedge mclk) begin
        if (wr.en) begin
            for (int i = 0; i < CMD_WORD_BITS / 8; i++) begin
                if (wr.strb[i]) begin
                    mem[wr.addr][i*8 +: 8] <= wr.data[i*8 +: 8];
                end
            end
        end
    end

    // registered read that holds while rd_en is low
    always_ff @(posedge mclk) begin
        if (rd_en) begin
            rd_word <= cmd_word_u'(mem[rd_addr]);
        end
    end

endmodule

// File: hw/cmd_sequencer.sv
// ----------------------------------------------------------
// ddr3 command sequencer control
// run start, fetch address, fetch-valid flag, nop pause
// counting and end of sequence on a done nop
// ----------------------------------------------------------
module cmd_sequencer (
    input  logic                                    mclk,
    input  logic                                    rst,
    input  logic [ddr_seq_pkg::CMD_MEM_AW-1:0]      run_addr,
    input  logic                                    run_seq,
    input  logic                                    is_nop,
    input  logic [ddr_seq_pkg::CMD_PAUSE_BITS-1:0]  pause_len,
    input  logic                                    done,
    output logic                                    rd_en,
    output logic [ddr_seq_pkg::CMD_MEM_AW-1:0]      rd_addr,
    output logic                                    word_valid,
    output logic                                    run_busy,
    output logic                                    run_done
);
    import ddr_seq_pkg::*;

    logic [CMD_PAUSE_BITS-1:0] pause_cntr;  // remaining stall cycles
    logic                      done_pend;   // done nop seen, pause running
    logic                      nop_pause;   // fresh nop with nonzero pause
    logic                      hold_now;    // stop the read this cycle
    logic                      finish;      // last nop cycle next

    assign nop_pause = word_valid && is_nop && (pause_len != '0);
    assign hold_now  = nop_pause || (word_valid && is_nop && done);

    // next read only when running, not stalled and not ending
    assign rd_en = run_busy && !run_done && !done_pend && !hold_now
                   && (pause_cntr == '0);

    // done without pause ends at once, otherwise when the pause runs out
    assign finish = done_pend ? (pause_cntr == '0)
                              : (word_valid && is_nop && done && (pause_len == '0));

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            run_busy   <= 1'b0;
            run_done   <= 1'b0;
            word_valid <= 1'b0;
            rd_addr    <= '0;
            pause_cntr <= '0;
            done_pend  <= 1'b0;
        end else begin
            word_valid <= rd_en;            // word arrives one cycle after read
            run_done   <= finish;           // one-cycle pulse

            if (!run_busy) begin
                if (run_seq) begin
                    run_busy <= 1'b1;
                    rd_addr  <= run_addr;   // bank bit included
                end
            end else if (run_done) begin
                run_busy <= 1'b0;
            end

            // step inside the bank, bank bit fixed
            if (rd_en) begin
                rd_addr <= {rd_addr[CMD_MEM_AW-1], rd_addr[CMD_BANK_AW-1:0] + 1'b1};
            end

            // first stall cycle is the nop fetch cycle itself
            if (nop_pause) begin
                pause_cntr <= pause_len - 1'b1;
            end else if (pause_cntr != '0) begin
                pause_cntr <= pause_cntr - 1'b1;
            end

            if (finish) begin
                done_pend <= 1'b0;
            end else if (nop_pause && done) begin
                done_pend <= 1'b1;
            end
        end
    end

    // start requests only arrive while idle
    property p_run_when_idle;
        @(posedge mclk) disable iff (rst)
        run_seq |-> !run_busy;
    endproperty

    a_run_when_idle : assert property (p_run_when_idle)
        else $error("run_seq sampled while sequencer busy");

    // no fetch while a pause is counting down
    property p_no_read_in_pause;
        @(posedge mclk) disable iff (rst)
        (pause_cntr != '0) |-> !rd_en;
    endproperty

    a_no_read_in_pause : assert property (p_no_read_in_pause)
        else $error("command read during pause");

endmodule

// File: hw/ddr_cmd_out.sv
// ----------------------------------------------------------
// ddr3 command line register
// decodes the fetched word into active or nop view and
// registers ras/cas/we, bank, address, cke and odt
// ----------------------------------------------------------
module ddr_cmd_out (
    input  logic                                    mclk,
    input  logic                                    rst,
    input  ddr_seq_pkg::cmd_word_u                  word,
    input  logic                                    word_valid,
    output logic                                    is_nop,
    output logic [ddr_seq_pkg::CMD_PAUSE_BITS-1:0]  pause_len,
    output logic                                    done,
    output ddr_seq_pkg::ddr_cmd_t                   ddr_cmd
);
    import ddr_seq_pkg::*;

    // nop when ras, cas and we are all high
    assign is_nop    = word.active.ras_n && word.active.cas_n && word.active.we_n;
    assign pause_len = word.nop.pause;
    assign done      = word.nop.done;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            ddr_cmd.ras_n <= 1'b1;          // nop after reset
            ddr_cmd.cas_n <= 1'b1;
            ddr_cmd.we_n  <= 1'b1;
            ddr_cmd.ba    <= '0;
            ddr_cmd.addr  <= '0;
            ddr_cmd.cke   <= 1'b0;
            ddr_cmd.odt   <= 1'b0;
        end else if (word_valid && !is_nop) begin
            ddr_cmd.ras_n <= word.active.ras_n;
            ddr_cmd.cas_n <= word.active.cas_n;
            ddr_cmd.we_n  <= word.active.we_n;
            ddr_cmd.ba    <= word.active.ba;
            ddr_cmd.addr  <= word.active.addr;
            ddr_cmd.cke   <= word.active.cke;
            ddr_cmd.odt   <= word.active.odt;
        end else begin
            ddr_cmd.ras_n <= 1'b1;          // nop or idle, cke/odt kept
            ddr_cmd.cas_n <= 1'b1;
            ddr_cmd.we_n  <= 1'b1;
        end
    end

endmodule

// File: hw/ddr_seq_top.sv
// ----------------------------------------------------------
// ddr3 command sequencer top
// axi4-lite write slave, command memory, sequencer and
// command line register on one clock
// ----------------------------------------------------------
module ddr_seq_top (
    input  logic                                mclk,
    input  logic                                rst,
    input  ddr_seq_pkg::axil_wreq_t             wreq,
    output ddr_seq_pkg::axil_wrsp_t             wrsp,
    input  logic [ddr_seq_pkg::CMD_MEM_AW-1:0]  run_addr,
    input  logic                                run_seq,
    output logic                                run_busy,
    output logic                                run_done,
    output ddr_seq_pkg::ddr_cmd_t               ddr_cmd
);
    import ddr_seq_pkg::*;

    mem_wr_t                   mem_wr;      // bus write into memory
    logic                      rd_en;
    logic [CMD_MEM_AW-1:0]     rd_addr;
    cmd_word_u                 rd_word;     // fetched command
    logic                      word_valid;
    logic                      is_nop;
    logic [CMD_PAUSE_BITS-1:0] pause_len;
    logic                      done;

    cmd_axil_wr cmd_axil_wr_i (
        .mclk   (mclk),
        .rst    (rst),
        .wreq   (wreq),
        .wrsp   (wrsp),
        .mem_wr (mem_wr)
    );

    cmd_mem cmd_mem_i (
        .mclk    (mclk),
        .wr      (mem_wr),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_word (rd_word)
    );

    cmd_sequencer cmd_sequencer_i (
        .mclk       (mclk),
        .rst        (rst),
        .run_addr   (run_addr),
        .run_seq    (run_seq),
        .is_nop     (is_nop),
        .pause_len  (pause_len),
        .done       (done),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .word_valid (word_valid),
        .run_busy   (run_busy),
        .run_done   (run_done)
    );

    ddr_cmd_out ddr_cmd_out_i (
        .mclk       (mclk),
        .rst        (rst),
        .word       (rd_word),
        .word_valid (word_valid),
        .is_nop     (is_nop),
        .pause_len  (pause_len),
        .done       (done),
        .ddr_cmd    (ddr_cmd)
    );

endmodule

// File: dv/ddr_seq_tb.sv
// ----------------------------------------------------------
// ddr3 command sequencer testbench
// loads command memory over axi4-lite, starts runs and
// checks the command lines against the stim file
// ----------------------------------------------------------
module ddr_seq_tb;
    import ddr_seq_pkg::*;

    logic                  mclk;
    logic                  rst;
    axil_wreq_t            wreq;
    axil_wrsp_t            wrsp;
    logic [CMD_MEM_AW-1:0] run_addr;
    logic                  run_seq;
    logic                  run_busy;
    logic                  run_done;
    ddr_cmd_t              ddr_cmd;

    int       done_count;       // run_done samples in this run
    logic     last_done;        // run_done at the latest sample
    ddr_cmd_t last_cmd;         // last expected active command
    int       cmd_checks;       // active commands compared so far

    ddr_seq_top ddr_seq_top_i (
        .mclk     (mclk),
        .rst      (rst),
        .wreq     (wreq),
        .wrsp     (wrsp),
        .run_addr (run_addr),
        .run_seq  (run_seq),
        .run_busy (run_busy),
        .run_done (run_done),
        .ddr_cmd  (ddr_cmd)
    );

    initial begin
        mclk = 1'b0;
        forever #4 mclk = ~mclk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string msg);
        $display("ERROR @%0t: %s", $time, msg);
        abort_run("mismatch against expected value");
    endtask

    // every sample point is a falling edge
    task automatic tick();
        @(negedge mclk);
        last_done = run_done;
        if (run_done) done_count++;
    endtask

    task automatic check_bresp(input axil_wrsp_t got);
        axil_wrsp_t exp;
        exp = '{awready: 1'b0, wready: 1'b0, bvalid: 1'b1, bresp: AXIL_RESP_OKAY};
        if (got !== exp) value_error($sformatf("bresp got %b exp %b", got, exp));
    endtask

    task automatic check_cmd(input ddr_cmd_t got, input ddr_cmd_t exp);
        cmd_checks++;
        if (got !== exp) begin
            value_error($sformatf("cmd got ras%b cas%b we%b ba%h a%h cke%b odt%b, exp %h",
                got.ras_n, got.cas_n, got.we_n, got.ba, got.addr, got.cke, got.odt, exp));
        end
    endtask

    // nop cycles with held cke and odt
    task automatic check_nop_run(input int count);
        for (int i = 0; i < count; i++) begin
            tick();
            if ({ddr_cmd.ras_n, ddr_cmd.cas_n, ddr_cmd.we_n} !== 3'b111
                || ddr_cmd.cke !== last_cmd.cke || ddr_cmd.odt !== last_cmd.odt) begin
                value_error($sformatf("nop cycle %0d of %0d got %h", i + 1, count, ddr_cmd));
            end
        end
    endtask

    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        int n;
        int delay;
        wreq.awaddr  = addr;
        wreq.wdata   = data;
        wreq.wstrb   = strb;
        wreq.awvalid = 1'b1;
        wreq.wvalid  = 1'b1;
        n = 0;
        do begin
            tick();
            n++;
            if (n > 16) abort_run("timeout waiting for write response");
        end while (!wrsp.bvalid);
        check_bresp(wrsp);
        delay = $urandom % 4;       // valids stay up and must not be taken again
        repeat (delay) begin
            tick();
            check_bresp(wrsp);
        end
        wreq.awvalid = 1'b0;
        wreq.wvalid  = 1'b0;
        wreq.bready  = 1'b1;
        tick();
        if (wrsp.bvalid) value_error("bvalid still high after bready");
        wreq.bready = 1'b0;
    endtask

    task automatic start_run(input logic [CMD_MEM_AW-1:0] addr);
        int n;
        n = 0;
        while (run_busy) begin
            tick();
            n++;
            if (n > 64) abort_run("timeout waiting for sequencer idle");
        end
        done_count = 0;
        run_addr   = addr;
        run_seq    = 1'b1;
        tick();
        run_seq = 1'b0;
        tick();                     // first command on the third sample
    endtask

    task automatic expect_done();
        if (done_count != 1 || !last_done) value_error("run_done not a single final pulse");
        tick();
        if (run_busy !== 1'b0) value_error("run_busy still high after run_done");
        check_nop_run(4);           // nothing after the done word
        if (done_count != 1) value_error("extra run_done pulse");
    endtask

    initial begin
        int       fd;
        string    line;
        int       a, b, c, d, e, f, g;
        ddr_cmd_t exp;
        void'($urandom(12210));
        rst        = 1'b1;
        wreq       = '0;
        run_addr   = '0;
        run_seq    = 1'b0;
        done_count = 0;
        cmd_checks = 0;
        last_done  = 1'b0;
        last_cmd   = '{ras_n: 1'b1, cas_n: 1'b1, we_n: 1'b1, default: '0};
        repeat (8) @(negedge mclk);
        rst = 1'b0;
        fd = $fopen("dv/ddr_seq_stim.txt", "r");
        if (fd == 0) abort_run("cannot open stimulus file dv/ddr_seq_stim.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0) continue;
            case (line[0])
                "W": begin
                    void'($sscanf(line, "W %h %h %h", a, b, c));
                    axil_write(a[11:0], b, c[3:0]);
                end
                "R": begin
                    void'($sscanf(line, "R %h", a));
                    start_run(a[CMD_MEM_AW-1:0]);
                end
                "C": begin
                    void'($sscanf(line, "C %h %h %h %h %h %h %h", a, b, c, d, e, f, g));
                    exp = '{ras_n: a[0], cas_n: b[0], we_n: c[0], ba: d[2:0],
                            addr: e[14:0], cke: f[0], odt: g[0]};
                    tick();
                    check_cmd(ddr_cmd, exp);
                    last_cmd = exp;
                end
                "N": begin
                    void'($sscanf(line, "N %d", a));
                    check_nop_run(a);
                end
                "D": expect_done();
                default: ;          // comments and blank lines
            endcase
        end
        $fclose(fd);
        if (cmd_checks > 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            abort_run("no command checks found in stimulus file");
        end
    end

endmodule

// File: ddr_seq.f
hw/ddr_seq_pkg.sv
hw/cmd_axil_wr.sv
hw/cmd_mem.sv
hw/cmd_sequencer.sv
hw/ddr_cmd_out.sv
hw/ddr_seq_top.sv
dv/ddr_seq_tb.sv

// File: Bender.yml
package:
  name: ddr_seq

sources:
  - files:
      - hw/ddr_seq_pkg.sv
      - hw/cmd_axil_wr.sv
      - hw/cmd_mem.sv
      - hw/cmd_sequencer.sv
      - hw/ddr_cmd_out.sv
      - hw/ddr_seq_top.sv
  - target: test
    files:
      - dv/ddr_seq_tb.sv

// File: dv/ddr_seq_stim.txt
# W byte_addr data strb | R run_addr | C ras cas we ba addr cke odt
# N nop_cycles | D run ends here
W 000 00218018 f
W 004 001c0002 f
W 008 00280400 f
W 00c 00640000 f
W 010 001c0000 f
W 014 006e9234 f
W 018 001c0041 f
W 01c 00200123 f
W 400 00688008 f
W 404 006c8010 f
W 404 ff1f2233 3
W 408 001c0040 f
W 40c 00200777 f
R 000
C 0 0 0 3 0018 1 0
N 3
C 0 1 0 0 0400 1 0
C 0 0 1 0 0000 1 1
N 1
C 0 1 1 5 1234 1 1
N 2
D
R 100
C 0 1 0 1 0008 1 1
C 0 1 1 0 2233 1 1
N 1
D
